// ==== postadd_consts.svh ====
`ifndef POSTADD_CONSTS_SVH
`define POSTADD_CONSTS_SVH

// Limb layout of the redundant polynomials
`define PA_ADD_DIV 4
`define PA_LIMB_BITS 16
`define PA_FP_BITS 64

// Signed carry kept by each L3 limb
`define PA_L3_CARRY_BITS 8

// Entries per register file in lanes 2 and 3
`define PA_REG_DEPTH 4

// Resolved integer width, wide enough for the carries above the top limb
`define PA_RES_BITS 72

// Field modulus p, the largest 64-bit prime
`define PA_MOD 64'hFFFF_FFFF_FFFF_FFC5

`endif

// ==== postadd_pkg.sv ====
`include "postadd_consts.svh"

package postadd_pkg;

    ////////////////////
    // L1 form

    // Multiplier output limb, one carry bit above the value
    typedef struct packed {
        logic                     carry;
        logic [`PA_LIMB_BITS-1:0] val;
    } limb_l1_t;

    typedef limb_l1_t [`PA_ADD_DIV-1:0] poly_l1_t;

    ////////////////////
    // L3 form

    // Accumulator limb, carry is two's complement
    typedef struct packed {
        logic signed [`PA_L3_CARRY_BITS-1:0] carry;
        logic        [`PA_LIMB_BITS-1:0]     val;
    } limb_l3_t;

    typedef limb_l3_t [`PA_ADD_DIV-1:0] poly_l3_t;

    ////////////////////
    // Lane operations

    // Encoding follows the external mode codes
    typedef enum logic [2:0] {
        OP_HOLD         = 3'b000,
        OP_LOAD         = 3'b001,
        OP_ADD          = 3'b010,
        OP_IN_MINUS_REG = 3'b011,
        OP_REG_MINUS_IN = 3'b100,
        OP_P_MINUS_REG  = 3'b101
    } acc_op_t;

endpackage

// ==== postadd_ctrl_if.sv ====
`timescale 1ns/10ps

// Decoded command from the decode stage to the accumulator lanes
interface postadd_ctrl_if;

    // Widened input polynomial
    postadd_pkg::poly_l3_t operand;

    // One operation per lane
    postadd_pkg::acc_op_t op1;
    postadd_pkg::acc_op_t op2;
    postadd_pkg::acc_op_t op3;

    // Register file indices for lanes 2 and 3
    logic [1:0] addr2;
    logic [1:0] addr3;

    // Lane whose result goes to the output
    logic [1:0] outsel;

    modport src (
        output operand,
        output op1,
        output op2,
        output op3,
        output addr2,
        output addr3,
        output outsel
    );

    modport dst (
        input operand,
        input op1,
        input op2,
        input op3,
        input addr2,
        input addr3,
        input outsel
    );

endinterface

// ==== poly_adder_l3.sv ====
`timescale 1ns/10ps
`include "postadd_consts.svh"

module poly_adder_l3 (
    input  postadd_pkg::poly_l3_t x,
    input  postadd_pkg::poly_l3_t y,
    input  logic                  sub,
    output postadd_pkg::poly_l3_t z
);

    localparam int LB = `PA_LIMB_BITS;
    localparam int CW = `PA_L3_CARRY_BITS;

    // Each limb is independent, the carry out of the value stays in the limb
    for (genvar i = 0; i < `PA_ADD_DIV; i++) begin : g_limb
        logic [LB:0]   v_sum;
        logic [LB:0]   v_diff;
        logic [CW-1:0] c_sum;
        logic [CW-1:0] c_diff;

        assign v_sum  = {1'b0, x[i].val} + {1'b0, y[i].val};
        assign v_diff = {1'b0, x[i].val} - {1'b0, y[i].val};

        // Top bit is +1 on add overflow, -1 on subtract borrow
        assign c_sum  = x[i].carry + y[i].carry + CW'(v_sum[LB]);
        assign c_diff = x[i].carry - y[i].carry - CW'(v_diff[LB]);

        assign z[i].val   = sub ? v_diff[LB-1:0] : v_sum[LB-1:0];
        assign z[i].carry = sub ? c_diff : c_sum;
    end

endmodule

// ==== mode_decode_stage.sv ====
`timescale 1ns/10ps
`include "postadd_consts.svh"

module mode_decode_stage (
    input  logic                  clk,
    input  logic                  rstn,
    input  postadd_pkg::poly_l1_t in_l1,
    input  logic [2:0]            mode1,
    input  logic [2:0]            mode2,
    input  logic [2:0]            mode3,
    input  logic [1:0]            addr2,
    input  logic [1:0]            addr3,
    input  logic [1:0]            outsel,
    postadd_ctrl_if.src           ctrl
);

    localparam int CW = `PA_L3_CARRY_BITS;

    ////////////////////
    // Helpers

    // L1 to L3, carry bit is zero extended
    function automatic postadd_pkg::poly_l3_t widen_l1(input postadd_pkg::poly_l1_t p);
        postadd_pkg::poly_l3_t w;
        w = '0;
        for (int i = 0; i < `PA_ADD_DIV; i++) begin
            w[i].val   = p[i].val;
            w[i].carry = CW'(p[i].carry);
        end
        return w;
    endfunction

    // Unused codes fall back to hold
    function automatic postadd_pkg::acc_op_t decode_mode(input logic [2:0] m);
        case (m)
            3'b000:  return postadd_pkg::OP_HOLD;
            3'b001:  return postadd_pkg::OP_LOAD;
            3'b010:  return postadd_pkg::OP_ADD;
            3'b011:  return postadd_pkg::OP_IN_MINUS_REG;
            3'b100:  return postadd_pkg::OP_REG_MINUS_IN;
            3'b101:  return postadd_pkg::OP_P_MINUS_REG;
            default: return postadd_pkg::OP_HOLD;
        endcase
    endfunction

    ////////////////////
    // Input register

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ctrl.operand <= '0;
            ctrl.op1     <= postadd_pkg::OP_HOLD;
            ctrl.op2     <= postadd_pkg::OP_HOLD;
            ctrl.op3     <= postadd_pkg::OP_HOLD;
            ctrl.addr2   <= '0;
            ctrl.addr3   <= '0;
            ctrl.outsel  <= '0;
        end else begin
            ctrl.operand <= widen_l1(in_l1);
            ctrl.op1     <= decode_mode(mode1);
            ctrl.op2     <= decode_mode(mode2);
            ctrl.op3     <= decode_mode(mode3);
            ctrl.addr2   <= addr2;
            ctrl.addr3   <= addr3;
            ctrl.outsel  <= outsel;
        end
    end

    ////////////////////
    // Command checks

    // The upstream sequencer only issues the six defined modes
    a_mode_legal: assert property (
        @(posedge clk) disable iff (!rstn)
        (mode1 <= 3'b101) && (mode2 <= 3'b101) && (mode3 <= 3'b101)
    );

    // Only three lanes can be selected
    a_outsel_legal: assert property (
        @(posedge clk) disable iff (!rstn)
        outsel != 2'b11
    );

endmodule

// ==== postadder.sv ====
`timescale 1ns/10ps
`include "postadd_consts.svh"

module postadder (
    input  logic                  clk,
    input  logic                  rstn,
    postadd_ctrl_if.dst           ctrl,
    output postadd_pkg::poly_l3_t dout
);

    localparam int LB    = `PA_LIMB_BITS;
    localparam int DEPTH = `PA_REG_DEPTH;
    localparam logic [`PA_FP_BITS-1:0] MOD = `PA_MOD;

    // Lane 1 register and the two register files
    postadd_pkg::poly_l3_t reg1;
    postadd_pkg::poly_l3_t file2 [DEPTH];
    postadd_pkg::poly_l3_t file3 [DEPTH];

    // Second pipeline register and the output select that travels with it
    postadd_pkg::poly_l3_t dly [3];
    logic [1:0]            dly_outsel;

    postadd_pkg::acc_op_t  op [3];
    postadd_pkg::poly_l3_t g [3];
    postadd_pkg::poly_l3_t acc_out [3];
    postadd_pkg::poly_l3_t poly_p;

    // Modulus as an L3 polynomial with zero carries
    for (genvar i = 0; i < `PA_ADD_DIV; i++) begin : g_mod
        assign poly_p[i].val   = MOD[i*LB +: LB];
        assign poly_p[i].carry = '0;
    end

    assign op[0] = ctrl.op1;
    assign op[1] = ctrl.op2;
    assign op[2] = ctrl.op3;

    // Current register value seen by each lane
    assign g[0] = reg1;
    assign g[1] = file2[ctrl.addr2];
    assign g[2] = file3[ctrl.addr3];

    ////////////////////
    // Accumulator lanes

    for (genvar l = 0; l < 3; l++) begin : g_lane
        postadd_pkg::poly_l3_t a_in;
        postadd_pkg::poly_l3_t b_in;
        logic                  sub;

        // Hold and load add onto zero
        always_comb begin
            case (op[l])
                postadd_pkg::OP_ADD,
                postadd_pkg::OP_IN_MINUS_REG: a_in = ctrl.operand;
                postadd_pkg::OP_REG_MINUS_IN: a_in = g[l];
                postadd_pkg::OP_P_MINUS_REG:  a_in = poly_p;
                default:                      a_in = '0;
            endcase
        end

        assign b_in = (op[l] == postadd_pkg::OP_LOAD || op[l] == postadd_pkg::OP_REG_MINUS_IN)
                    ? ctrl.operand : g[l];

        assign sub = (op[l] == postadd_pkg::OP_IN_MINUS_REG) ||
                     (op[l] == postadd_pkg::OP_REG_MINUS_IN) ||
                     (op[l] == postadd_pkg::OP_P_MINUS_REG);

        poly_adder_l3 i_acc (
            .x   (a_in),
            .y   (b_in),
            .sub (sub),
            .z   (acc_out[l])
        );
    end

    ////////////////////
    // State and output

    always_ff @(posedge clk) begin
        if (!rstn) begin
            reg1 <= '0;
            for (int k = 0; k < DEPTH; k++) begin
                file2[k] <= '0;
                file3[k] <= '0;
            end
            for (int k = 0; k < 3; k++) begin
                dly[k] <= '0;
            end
            dly_outsel <= '0;
            dout       <= '0;
        end else begin
            // Write back so the next command sees this result
            reg1               <= acc_out[0];
            file2[ctrl.addr2]  <= acc_out[1];
            file3[ctrl.addr3]  <= acc_out[2];
            for (int k = 0; k < 3; k++) begin
                dly[k] <= acc_out[k];
            end
            dly_outsel <= ctrl.outsel;

            case (dly_outsel)
                2'b00:   dout <= dly[0];
                2'b01:   dout <= dly[1];
                2'b10:   dout <= dly[2];
                default: dout <= '0;
            endcase
        end
    end

    // Select from the decode stage must still be legal one stage later
    a_dly_outsel_legal: assert property (
        @(posedge clk) disable iff (!rstn)
        dly_outsel != 2'b11
    );

endmodule

// ==== carry_resolver.sv ====
`timescale 1ns/10ps
`include "postadd_consts.svh"

module carry_resolver (
    input  logic                        clk,
    input  logic                        rstn,
    input  postadd_pkg::poly_l3_t       din,
    output logic [`PA_RES_BITS-1:0]     result
);

    localparam int RW = `PA_RES_BITS;
    localparam int LB = `PA_LIMB_BITS;
    localparam int CW = `PA_L3_CARRY_BITS;

    logic [RW-1:0] sum;

    ////////////////////
    // Carry collapse

    // Carry of limb i weighs 2^(16(i+1)), value weighs 2^(16i)
    always_comb begin
        sum = '0;
        for (int i = 0; i < `PA_ADD_DIV; i++) begin
            sum = sum + ({{(RW-CW){din[i].carry[CW-1]}}, din[i].carry} << (LB*(i+1)));
            sum = sum + (RW'(din[i].val) << (LB*i));
        end
    end

    // Wraps modulo 2^72, negative totals come out as two's complement
    always_ff @(posedge clk) begin
        if (!rstn) begin
            result <= '0;
        end else begin
            result <= sum;
        end
    end

endmodule

// ==== postadd_top.sv ====
`timescale 1ns/10ps
`include "postadd_consts.svh"

module postadd_top (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [`PA_FP_BITS-1:0]    in_val,
    input  logic [`PA_ADD_DIV-1:0]    in_carry,
    input  logic [2:0]                mode1,
    input  logic [2:0]                mode2,
    input  logic [2:0]                mode3,
    input  logic [1:0]                addr2,
    input  logic [1:0]                addr3,
    input  logic [1:0]                outsel,
    output logic [`PA_RES_BITS-1:0]   result
);

    localparam int LB = `PA_LIMB_BITS;

    postadd_pkg::poly_l1_t in_l1;
    postadd_pkg::poly_l3_t acc_dout;

    postadd_ctrl_if ctrl_if ();

    // One carry bit per limb, sitting just above that limb
    for (genvar i = 0; i < `PA_ADD_DIV; i++) begin : g_pack
        assign in_l1[i].val   = in_val[i*LB +: LB];
        assign in_l1[i].carry = in_carry[i];
    end

    ////////////////////
    // Pipeline stages

    mode_decode_stage i_decode (
        .clk    (clk),
        .rstn   (rstn),
        .in_l1  (in_l1),
        .mode1  (mode1),
        .mode2  (mode2),
        .mode3  (mode3),
        .addr2  (addr2),
        .addr3  (addr3),
        .outsel (outsel),
        .ctrl   (ctrl_if.src)
    );

    postadder i_postadder (
        .clk  (clk),
        .rstn (rstn),
        .ctrl (ctrl_if.dst),
        .dout (acc_dout)
    );

    carry_resolver i_resolver (
        .clk    (clk),
        .rstn   (rstn),
        .din    (acc_dout),
        .result (result)
    );

endmodule

// ==== tb_postadd_top.sv ====
`timescale 1ns/10ps
`include "postadd_consts.svh"

module tb_postadd_top;

    localparam int N_DIRECTED = 64;
    localparam int N_RANDOM   = 2000;
    localparam int WATCHDOG_NS = (N_DIRECTED + N_RANDOM) * 100 + 50 * 100;
    localparam int RW = `PA_RES_BITS;

    // Mode codes seen at the top level
    localparam logic [2:0] M_HOLD = 3'd0;
    localparam logic [2:0] M_LOAD = 3'd1;
    localparam logic [2:0] M_ADD  = 3'd2;
    localparam logic [2:0] M_IMR  = 3'd3;
    localparam logic [2:0] M_RMI  = 3'd4;
    localparam logic [2:0] M_PMR  = 3'd5;

    logic          clk;
    logic          rstn;
    logic [63:0]   in_val;
    logic [3:0]    in_carry;
    logic [2:0]    mode1;
    logic [2:0]    mode2;
    logic [2:0]    mode3;
    logic [1:0]    addr2;
    logic [1:0]    addr3;
    logic [1:0]    outsel;
    logic [RW-1:0] result;

    // Model state as plain integers modulo 2^72
    logic [RW-1:0] m_reg1;
    logic [RW-1:0] m_file2 [4];
    logic [RW-1:0] m_file3 [4];
    logic [RW-1:0] exp_q [$];

    logic [15:0] lfsr;
    int          n_checks;
    int          n_errors;
    int          cnt1;
    int          cnt2 [4];
    int          cnt3 [4];

    postadd_top i_dut (
        .clk      (clk),
        .rstn     (rstn),
        .in_val   (in_val),
        .in_carry (in_carry),
        .mode1    (mode1),
        .mode2    (mode2),
        .mode3    (mode3),
        .addr2    (addr2),
        .addr3    (addr3),
        .outsel   (outsel),
        .result   (result)
    );

    always #50 clk = ~clk;

    ////////////////////
    // Random source

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[15]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    ////////////////////
    // Reference model

    function automatic logic [RW-1:0] lane_result(input logic [2:0] op,
                                                  input logic [RW-1:0] i,
                                                  input logic [RW-1:0] g);
        case (op)
            M_LOAD:  return i;
            M_ADD:   return i + g;
            M_IMR:   return i - g;
            M_RMI:   return g - i;
            M_PMR:   return RW'(`PA_MOD) - g;
            default: return g;
        endcase
    endfunction

    task automatic check_result();
        logic [RW-1:0] e;
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            n_checks++;
            assert (result === e) else begin
                n_errors++;
                $display("[ERROR] result expected %h actual %h", e, result);
            end
        end
    endtask

    // One command per falling edge with its expected value queued for 4 cycles later
    task automatic issue_cmd(input logic [63:0] v, input logic [3:0] c,
                             input logic [2:0] m1, input logic [2:0] m2,
                             input logic [2:0] m3, input logic [1:0] a2,
                             input logic [1:0] a3, input logic [1:0] os);
        logic [RW-1:0] iv;
        logic [RW-1:0] r1;
        logic [RW-1:0] r2;
        logic [RW-1:0] r3;
        @(negedge clk);
        check_result();
        in_val   = v;
        in_carry = c;
        mode1    = m1;
        mode2    = m2;
        mode3    = m3;
        addr2    = a2;
        addr3    = a3;
        outsel   = os;
        iv = RW'(v);
        for (int i = 0; i < 4; i++) begin
            iv = iv + (RW'(c[i]) << (16 * (i + 1)));
        end
        r1 = lane_result(m1, iv, m_reg1);
        r2 = lane_result(m2, iv, m_file2[a2]);
        r3 = lane_result(m3, iv, m_file3[a3]);
        m_reg1      = r1;
        m_file2[a2] = r2;
        m_file3[a3] = r3;
        exp_q.push_back(os == 2'd0 ? r1 : (os == 2'd1 ? r2 : r3));
    endtask

    // Only one lane active while the others hold
    task automatic lane_cmd(input int lane, input logic [2:0] op, input logic [63:0] v,
                            input logic [3:0] c, input logic [1:0] addr);
        logic [2:0] m1;
        logic [2:0] m2;
        logic [2:0] m3;
        m1 = (lane == 0) ? op : M_HOLD;
        m2 = (lane == 1) ? op : M_HOLD;
        m3 = (lane == 2) ? op : M_HOLD;
        issue_cmd(v, c, m1, m2, m3, addr, addr, 2'(lane));
    endtask

    // Bounds the growth of the L3 carries
    function automatic int next_count(input logic [2:0] op, input int cnt);
        if (op == M_LOAD)
            return 0;
        if (op == M_HOLD)
            return cnt;
        return cnt + 1;
    endfunction

    ////////////////////
    // Watchdog

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the tests did not complete in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [63:0] v;
        logic [3:0]  c;
        logic [2:0]  m1;
        logic [2:0]  m2;
        logic [2:0]  m3;
        logic [1:0]  a2;
        logic [1:0]  a3;
        logic [1:0]  os;
        clk = 1'b0;
        rstn = 1'b0;
        in_val = '0;
        in_carry = '0;
        mode1 = M_HOLD;
        mode2 = M_HOLD;
        mode3 = M_HOLD;
        addr2 = '0;
        addr3 = '0;
        outsel = '0;
        lfsr = 16'd30969;
        n_checks = 0;
        n_errors = 0;
        m_reg1 = '0;
        for (int k = 0; k < 4; k++) begin
            m_file2[k] = '0;
            m_file3[k] = '0;
        end
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        // Pipeline still holds reset values for 4 cycles
        repeat (4) exp_q.push_back('0);

        // Idle with all lanes on hold
        repeat (8) issue_cmd('0, '0, M_HOLD, M_HOLD, M_HOLD, 2'd0, 2'd0, 2'd0);

        // Load then add chains
        for (int l = 0; l < 3; l++) begin
            lane_cmd(l, M_LOAD, rand_bits(64), 4'(rand_bits(4)), 2'd0);
            repeat (3) lane_cmd(l, M_ADD, rand_bits(64), 4'(rand_bits(4)), 2'd0);
        end

        // Subtractions going negative
        for (int l = 0; l < 3; l++) begin
            lane_cmd(l, M_LOAD, 64'h10, 4'h0, 2'd1);
            lane_cmd(l, M_IMR, 64'h5, 4'h0, 2'd1);
            lane_cmd(l, M_LOAD, 64'h1_0000, 4'h0, 2'd1);
            lane_cmd(l, M_RMI, 64'h0000_0100_0000_0000, 4'h1, 2'd1);
        end

        // p minus a loaded register
        for (int l = 0; l < 3; l++) begin
            lane_cmd(l, M_LOAD, rand_bits(64), 4'(rand_bits(4)), 2'd2);
            lane_cmd(l, M_PMR, '0, '0, 2'd2);
        end

        // Separate file entries with lane 3 addressed in reverse
        for (int a = 0; a < 4; a++) begin
            issue_cmd(rand_bits(64), 4'(rand_bits(4)), M_HOLD, M_LOAD, M_LOAD,
                      2'(a), 2'(3 - a), 2'(1 + a % 2));
        end
        for (int a = 0; a < 4; a++) begin
            lane_cmd(1, M_HOLD, '0, '0, 2'(a));
            lane_cmd(2, M_HOLD, '0, '0, 2'(a));
        end
        // Back to back on one address
        repeat (3) lane_cmd(1, M_ADD, rand_bits(64), 4'(rand_bits(4)), 2'd2);
        repeat (3) lane_cmd(2, M_ADD, rand_bits(64), 4'(rand_bits(4)), 2'd2);
        for (int a = 0; a < 4; a++) begin
            lane_cmd(1, M_HOLD, '0, '0, 2'(a));
            lane_cmd(2, M_HOLD, '0, '0, 2'(a));
        end

        ////////////////////
        // Random run

        cnt1 = 15;
        for (int k = 0; k < 4; k++) begin
            cnt2[k] = 15;
            cnt3[k] = 15;
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            v  = rand_bits(64);
            c  = 4'(rand_bits(4));
            m1 = 3'(rand_bits(3) % 6);
            m2 = 3'(rand_bits(3) % 6);
            m3 = 3'(rand_bits(3) % 6);
            a2 = 2'(rand_bits(2));
            a3 = 2'(rand_bits(2));
            os = 2'(rand_bits(2) % 3);
            if (cnt1 >= 15)
                m1 = M_LOAD;
            if (cnt2[a2] >= 15)
                m2 = M_LOAD;
            if (cnt3[a3] >= 15)
                m3 = M_LOAD;
            cnt1     = next_count(m1, cnt1);
            cnt2[a2] = next_count(m2, cnt2[a2]);
            cnt3[a3] = next_count(m3, cnt3[a3]);
            issue_cmd(v, c, m1, m2, m3, a2, a3, os);
        end

        // Drain the last results
        repeat (4) begin
            @(negedge clk);
            check_result();
            mode1 = M_HOLD;
            mode2 = M_HOLD;
            mode3 = M_HOLD;
        end

        $display("Checks: %0d  Errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
postadd_pkg.sv
postadd_ctrl_if.sv
poly_adder_l3.sv
mode_decode_stage.sv
postadder.sv
carry_resolver.sv
postadd_top.sv
tb_postadd_top.sv

// ==== Bender.yml ====
package:
  name: postadd

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - postadd_pkg.sv
      - postadd_ctrl_if.sv
      - poly_adder_l3.sv
      - mode_decode_stage.sv
      - postadder.sv
      - carry_resolver.sv
      - postadd_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_postadd_top.sv
